/* sim/hazard_vectors.txt */
// type rs1 rs2 rd exe_ctrl exe_src mem_ctrl wb_ctrl csr trap exp_trap producer
// All hex, producer ff means no earlier producer line
0 01 02 05 01 1 0 1 000 0 0 ff
1 05 06 00 01 1 0 0 000 0 0 00
0 03 00 07 01 2 3 2 000 0 0 ff
2 07 00 01 01 2 0 4 000 0 0 02
0 09 00 08 01 4 0 5 300 0 0 ff
0 00 00 0a 01 6 0 7 300 0 0 04
0 08 00 0b 01 2 0 1 000 0 0 04
0 00 00 0c 01 3 0 3 000 2 2 ff
0 0d 0c 00 01 2 a 0 000 0 0 07
0 00 00 00 00 0 0 0 000 3 3 ff
0 00 00 01 01 3 0 4 000 0 0 ff
1 01 0c 00 01 1 0 0 000 0 0 0a
0 02 0b 00 01 2 b 0 000 0 0 06
0 00 00 0e 01 7 0 8 305 0 0 ff
0 0e 0e 0f 01 1 0 1 000 0 0 0d
0 00 00 00 00 0 0 0 000 b b ff
0 0f 00 10 01 5 0 6 300 0 0 0e
0 10 00 11 01 2 4 2 000 5 5 10
0 03 11 00 01 2 9 0 000 0 0 11
2 10 00 02 01 2 0 4 000 0 0 10

/* sources.f */
logic/hazard_pkg.sv
logic/issue_handshake_fsm.sv
logic/conflict_detector.sv
logic/pipe_stage_regs.sv
logic/retire_counter.sv
logic/hazard_unit_top.sv
sim/hazard_unit_props.sv
sim/hazard_unit_tb.sv

/* Bender.yml */
package:
  name: hazard_unit

sources:
  - files:
      - logic/hazard_pkg.sv
      - logic/issue_handshake_fsm.sv
      - logic/conflict_detector.sv
      - logic/pipe_stage_regs.sv
      - logic/retire_counter.sv
      - logic/hazard_unit_top.sv
  - target: simulation
    files:
      - sim/hazard_unit_props.sv
      - sim/hazard_unit_tb.sv

/* sim/hazard_unit_tb.sv */
// Hazard unit testbench
`default_nettype none

module hazard_unit_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period   = 8;
    localparam int reset_cycles = 5;
    localparam int vec_count    = 20;
    localparam int num_fields   = 12;
    localparam int max_cycles   = vec_count * 20 + reset_cycles;

    // Column order in the vector file
    localparam int f_type = 0;
    localparam int f_rs1  = 1;
    localparam int f_rs2  = 2;
    localparam int f_rd   = 3;
    localparam int f_exe  = 4;
    localparam int f_src  = 5;
    localparam int f_mem  = 6;
    localparam int f_wb   = 7;
    localparam int f_csr  = 8;
    localparam int f_trap = 9;
    localparam int f_exp  = 10;
    localparam int f_prod = 11;

    logic clk;
    logic rst;
    logic req;
    logic [hazard_pkg::type_w-1:0]     op_type;
    logic [hazard_pkg::reg_idx_w-1:0]  rs1;
    logic [hazard_pkg::reg_idx_w-1:0]  rs2;
    logic [hazard_pkg::reg_idx_w-1:0]  rd;
    logic [hazard_pkg::exe_ctrl_w-1:0] exe_ctrl;
    logic [hazard_pkg::exe_src_w-1:0]  exe_src;
    logic [hazard_pkg::mem_ctrl_w-1:0] mem_ctrl;
    logic [hazard_pkg::wb_ctrl_w-1:0]  wb_ctrl;
    logic [hazard_pkg::csr_addr_w-1:0] csr;
    logic [hazard_pkg::trap_w-1:0]     trap;
    logic                              ack;
    logic                              retire_valid;
    logic [hazard_pkg::reg_idx_w-1:0]  retire_rd;
    logic [hazard_pkg::wb_ctrl_w-1:0]  retire_wb_ctrl;
    logic [hazard_pkg::trap_w-1:0]     retire_trap;
    logic [hazard_pkg::count_w-1:0]    retire_count;
    logic [hazard_pkg::count_w-1:0]    trap_count;

    logic [11:0] vec_mem [vec_count*num_fields];
    int          retire_cycle [vec_count];
    int          cycle;
    int          issued;
    int          retired;
    logic [31:0] lfsr_state;

    hazard_unit_top i_hazard_unit_top (
        .clk(clk), .rst(rst), .req(req), .op_type(op_type), .rs1(rs1), .rs2(rs2),
        .rd(rd), .exe_ctrl(exe_ctrl), .exe_src(exe_src), .mem_ctrl(mem_ctrl),
        .wb_ctrl(wb_ctrl), .csr(csr), .trap(trap), .ack(ack),
        .retire_valid(retire_valid), .retire_rd(retire_rd),
        .retire_wb_ctrl(retire_wb_ctrl), .retire_trap(retire_trap),
        .retire_count(retire_count), .trap_count(trap_count)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [11:0] vec_field(input int idx, input int field);
        vec_field = vec_mem[idx*num_fields + field];
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic stop_run();
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped after an error");
    endtask

    task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
        if (actual !== expected) begin
            $display("MISMATCH at time %0t: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            stop_run();
        end
    endtask

    // Two LFSR bits give 0 to 3 idle cycles
    task automatic draw_gap(output int gap);
        gap = 0;
        for (int b = 0; b < 2; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            gap = (gap << 1) | lfsr_state[0];
        end
    endtask

    task automatic issue_op(input int idx);
        int gap;
        draw_gap(gap);
        repeat (gap) @(posedge clk);
        @(posedge clk);
        op_type  <= vec_mem[idx*num_fields + f_type][2:0];
        rs1      <= vec_mem[idx*num_fields + f_rs1][4:0];
        rs2      <= vec_mem[idx*num_fields + f_rs2][4:0];
        rd       <= vec_mem[idx*num_fields + f_rd][4:0];
        exe_ctrl <= vec_mem[idx*num_fields + f_exe][4:0];
        exe_src  <= vec_mem[idx*num_fields + f_src][2:0];
        mem_ctrl <= vec_mem[idx*num_fields + f_mem][3:0];
        wb_ctrl  <= vec_mem[idx*num_fields + f_wb][3:0];
        csr      <= vec_mem[idx*num_fields + f_csr];
        trap     <= vec_mem[idx*num_fields + f_trap][3:0];
        req      <= 1'b1;
        @(negedge clk);
        while (!ack) @(negedge clk);  // May wait out an ID stall
        issued++;
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        while (ack) @(negedge clk);
    endtask

    always @(posedge clk) begin
        if (rst) begin
            cycle <= 0;
        end else begin
            cycle <= cycle + 1;
        end
    end

    // Retire monitor checks that ops leave WB in issue order
    always @(negedge clk) begin
        if (!rst && retire_valid) begin
            if (retired >= issued) begin
                $display("Error: retire_valid seen with no issued op outstanding");
                stop_run();
            end
            check_eq(retire_rd, vec_field(retired, f_rd),
                     $sformatf("op %0d retire_rd", retired));
            check_eq(retire_wb_ctrl, vec_field(retired, f_wb),
                     $sformatf("op %0d retire_wb_ctrl", retired));
            check_eq(retire_trap, vec_field(retired, f_exp),
                     $sformatf("op %0d retire_trap", retired));
            retire_cycle[retired] = cycle;
            if (vec_field(retired, f_prod) != 12'h0ff) begin
                check_eq(vec_field(retired, f_prod) < retired, 1,
                         $sformatf("op %0d producer retired earlier", retired));
                check_eq(cycle >= retire_cycle[vec_field(retired, f_prod)] + 4, 1,
                         $sformatf("op %0d retires 4 cycles after its producer", retired));
            end
            retired++;
        end
    end

    initial begin
        #(max_cycles * clk_period);
        $display("Timeout: the run did not finish within %0d cycles", max_cycles);
        stop_run();
    end

    initial begin
        int exp_traps;
        clk        = 1'b0;
        rst        = 1'b1;
        req        = 1'b0;
        op_type    = '0;
        rs1        = '0;
        rs2        = '0;
        rd         = '0;
        exe_ctrl   = '0;
        exe_src    = '0;
        mem_ctrl   = '0;
        wb_ctrl    = '0;
        csr        = '0;
        trap       = '0;
        issued     = 0;
        retired    = 0;
        exp_traps  = 0;
        lfsr_state = 32'h398a;
        $readmemh("sim/hazard_vectors.txt", vec_mem);
        for (int k = 0; k < vec_count*num_fields; k++) begin
            if ($isunknown(vec_mem[k])) begin
                $display("Error: vector file is missing entries or holds bad values");
                stop_run();
            end
        end
        for (int i = 0; i < vec_count; i++) begin
            if (vec_field(i, f_exp) != 12'(hazard_pkg::trap_nop)) exp_traps++;
        end

        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_eq(ack, 1'b0, "ack after reset");
        check_eq(retire_valid, 1'b0, "retire_valid after reset");
        check_eq(retire_count, 0, "retire_count after reset");
        check_eq(trap_count, 0, "trap_count after reset");

        for (int i = 0; i < vec_count; i++) begin
            issue_op(i);
        end
        while (retired < vec_count) @(negedge clk);
        repeat (6) @(negedge clk);  // Room for any stray retire

        check_eq(retire_count, vec_count, "retire_count at end");
        check_eq(trap_count, exp_traps, "trap_count at end");
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/hazard_unit_props.sv */
// Hazard unit bound assertions
`default_nettype none

module hazard_unit_props (
    input logic                             clk,
    input logic                             rst,
    input logic                             req,
    input logic                             ack,
    input logic [hazard_pkg::count_w-1:0]   retire_count
);

    timeunit 1ns;
    timeprecision 100ps;

    ack_rise_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(req))
        else $error("ack rose while req was low");

    ack_fall_needs_req_low: assert property (@(posedge clk) disable iff (rst)
        $fell(ack) |-> !$past(req))
        else $error("ack fell while req was still high");

    // Steps by at most one, so only a wrap can look like a decrease
    count_monotonic: assert property (@(posedge clk) disable iff (rst)
        retire_count == $past(retire_count) || retire_count == $past(retire_count) + 1'b1)
        else $error("retire_count moved by other than zero or one");

endmodule

bind hazard_unit_top hazard_unit_props i_hazard_unit_props (
    .clk(clk), .rst(rst), .req(req), .ack(ack), .retire_count(retire_count)
);

`default_nettype wire

/* logic/hazard_unit_top.sv */
// Hazard control unit top
`default_nettype none

module hazard_unit_top (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                req,
    input  logic [hazard_pkg::type_w-1:0]       op_type,
    input  logic [hazard_pkg::reg_idx_w-1:0]    rs1,
    input  logic [hazard_pkg::reg_idx_w-1:0]    rs2,
    input  logic [hazard_pkg::reg_idx_w-1:0]    rd,
    input  logic [hazard_pkg::exe_ctrl_w-1:0]   exe_ctrl,
    input  logic [hazard_pkg::exe_src_w-1:0]    exe_src,
    input  logic [hazard_pkg::mem_ctrl_w-1:0]   mem_ctrl,
    input  logic [hazard_pkg::wb_ctrl_w-1:0]    wb_ctrl,
    input  logic [hazard_pkg::csr_addr_w-1:0]   csr,
    input  logic [hazard_pkg::trap_w-1:0]       trap,
    output logic                                ack,
    output logic                                retire_valid,
    output logic [hazard_pkg::reg_idx_w-1:0]    retire_rd,
    output logic [hazard_pkg::wb_ctrl_w-1:0]    retire_wb_ctrl,
    output logic [hazard_pkg::trap_w-1:0]       retire_trap,
    output logic [hazard_pkg::count_w-1:0]      retire_count,
    output logic [hazard_pkg::count_w-1:0]      trap_count
);

    logic capture;
    logic id_load_ok;
    logic id_conflict;
    logic exe_conflict;
    logic mem_conflict;
    logic id_valid_q, exe_valid_q, mem_valid_q, wb_valid_q;
    logic [hazard_pkg::type_w-1:0]     id_type_q;
    logic [hazard_pkg::reg_idx_w-1:0]  id_rs1_q, id_rs2_q, exe_rd_q, exe_rs1_q, exe_rs2_q;
    logic [hazard_pkg::reg_idx_w-1:0]  mem_rd_q, mem_rs2_q, wb_rd_q;
    logic [hazard_pkg::exe_ctrl_w-1:0] exe_ctrl_q;
    logic [hazard_pkg::exe_src_w-1:0]  exe_src_q;
    logic [hazard_pkg::mem_ctrl_w-1:0] mem_ctrl_q;
    logic [hazard_pkg::wb_ctrl_w-1:0]  exe_wb_ctrl_q, mem_wb_ctrl_q, wb_ctrl_q;
    logic [hazard_pkg::csr_addr_w-1:0] exe_csr_q, mem_csr_q, wb_csr_q;
    logic [hazard_pkg::trap_w-1:0]     id_trap_q, exe_trap_q, mem_trap_q, wb_trap_q;
    logic [hazard_pkg::trap_w-1:0]     wb_trap_masked;

    issue_handshake_fsm i_issue_handshake_fsm (
        .clk(clk), .rst(rst), .req(req), .id_load_ok(id_load_ok),
        .ack(ack), .capture(capture)
    );

    pipe_stage_regs i_pipe_stage_regs (
        .clk(clk), .rst(rst), .capture(capture),
        .issue_op_type(op_type), .issue_rs1(rs1), .issue_rs2(rs2), .issue_rd(rd),
        .issue_exe_ctrl(exe_ctrl), .issue_exe_src(exe_src), .issue_mem_ctrl(mem_ctrl),
        .issue_wb_ctrl(wb_ctrl), .issue_csr(csr), .issue_trap(trap),
        .id_conflict(id_conflict), .exe_conflict(exe_conflict),
        .mem_conflict(mem_conflict), .wb_trap(wb_trap_masked), .id_load_ok(id_load_ok),
        .id_valid(id_valid_q), .id_type(id_type_q), .id_rs1(id_rs1_q), .id_rs2(id_rs2_q),
        .id_trap(id_trap_q),
        .exe_valid(exe_valid_q), .exe_ctrl(exe_ctrl_q), .exe_src(exe_src_q),
        .exe_wb_ctrl(exe_wb_ctrl_q), .exe_rd(exe_rd_q), .exe_rs1(exe_rs1_q),
        .exe_rs2(exe_rs2_q), .exe_csr(exe_csr_q), .exe_trap(exe_trap_q),
        .mem_valid(mem_valid_q), .mem_ctrl(mem_ctrl_q), .mem_wb_ctrl(mem_wb_ctrl_q),
        .mem_rd(mem_rd_q), .mem_rs2(mem_rs2_q), .mem_csr(mem_csr_q), .mem_trap(mem_trap_q),
        .wb_valid(wb_valid_q), .wb_ctrl(wb_ctrl_q), .wb_rd(wb_rd_q), .wb_csr(wb_csr_q),
        .wb_trap_raw(wb_trap_q),
        .retire_valid(retire_valid), .retire_rd(retire_rd),
        .retire_wb_ctrl(retire_wb_ctrl), .retire_trap(retire_trap)
    );

    conflict_detector i_conflict_detector (
        .id_valid(id_valid_q), .id_type(id_type_q), .id_rs1(id_rs1_q), .id_rs2(id_rs2_q),
        .id_trap(id_trap_q),
        .exe_valid(exe_valid_q), .exe_ctrl(exe_ctrl_q), .exe_src(exe_src_q),
        .exe_wb_ctrl(exe_wb_ctrl_q), .exe_rd(exe_rd_q), .exe_rs1(exe_rs1_q),
        .exe_rs2(exe_rs2_q), .exe_csr(exe_csr_q), .exe_trap(exe_trap_q),
        .mem_valid(mem_valid_q), .mem_ctrl(mem_ctrl_q), .mem_wb_ctrl(mem_wb_ctrl_q),
        .mem_rd(mem_rd_q), .mem_rs2(mem_rs2_q), .mem_csr(mem_csr_q), .mem_trap(mem_trap_q),
        .wb_valid(wb_valid_q), .wb_ctrl(wb_ctrl_q), .wb_rd(wb_rd_q), .wb_csr(wb_csr_q),
        .wb_trap(wb_trap_q),
        .id_conflict(id_conflict), .exe_conflict(exe_conflict),
        .mem_conflict(mem_conflict), .wb_trap_out(wb_trap_masked)
    );

    retire_counter i_retire_counter (
        .clk(clk), .rst(rst), .retire_valid(retire_valid), .retire_trap(retire_trap),
        .retire_count(retire_count), .trap_count(trap_count)
    );

endmodule

`default_nettype wire

/* logic/retire_counter.sv */
// Retirement counters
`default_nettype none

module retire_counter (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             retire_valid,
    input  logic [hazard_pkg::trap_w-1:0]    retire_trap,
    output logic [hazard_pkg::count_w-1:0]   retire_count,
    output logic [hazard_pkg::count_w-1:0]   trap_count
);

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_count <= '0;
            trap_count   <= '0;
        end else if (retire_valid) begin
            retire_count <= retire_count + 1'b1;  // Wraps at full scale
            if (retire_trap != hazard_pkg::trap_nop) begin
                trap_count <= trap_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/pipe_stage_regs.sv */
// Pipeline stage registers
`default_nettype none

module pipe_stage_regs (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                capture,
    input  logic [hazard_pkg::type_w-1:0]       issue_op_type,
    input  logic [hazard_pkg::reg_idx_w-1:0]    issue_rs1,
    input  logic [hazard_pkg::reg_idx_w-1:0]    issue_rs2,
    input  logic [hazard_pkg::reg_idx_w-1:0]    issue_rd,
    input  logic [hazard_pkg::exe_ctrl_w-1:0]   issue_exe_ctrl,
    input  logic [hazard_pkg::exe_src_w-1:0]    issue_exe_src,
    input  logic [hazard_pkg::mem_ctrl_w-1:0]   issue_mem_ctrl,
    input  logic [hazard_pkg::wb_ctrl_w-1:0]    issue_wb_ctrl,
    input  logic [hazard_pkg::csr_addr_w-1:0]   issue_csr,
    input  logic [hazard_pkg::trap_w-1:0]       issue_trap,
    input  logic                                id_conflict,
    input  logic                                exe_conflict,
    input  logic                                mem_conflict,
    input  logic [hazard_pkg::trap_w-1:0]       wb_trap,
    output logic                                id_load_ok,
    output logic                                id_valid,
    output logic [hazard_pkg::type_w-1:0]       id_type,
    output logic [hazard_pkg::reg_idx_w-1:0]    id_rs1,
    output logic [hazard_pkg::reg_idx_w-1:0]    id_rs2,
    output logic [hazard_pkg::trap_w-1:0]       id_trap,
    output logic                                exe_valid,
    output logic [hazard_pkg::exe_ctrl_w-1:0]   exe_ctrl,
    output logic [hazard_pkg::exe_src_w-1:0]    exe_src,
    output logic [hazard_pkg::wb_ctrl_w-1:0]    exe_wb_ctrl,
    output logic [hazard_pkg::reg_idx_w-1:0]    exe_rd,
    output logic [hazard_pkg::reg_idx_w-1:0]    exe_rs1,
    output logic [hazard_pkg::reg_idx_w-1:0]    exe_rs2,
    output logic [hazard_pkg::csr_addr_w-1:0]   exe_csr,
    output logic [hazard_pkg::trap_w-1:0]       exe_trap,
    output logic                                mem_valid,
    output logic [hazard_pkg::mem_ctrl_w-1:0]   mem_ctrl,
    output logic [hazard_pkg::wb_ctrl_w-1:0]    mem_wb_ctrl,
    output logic [hazard_pkg::reg_idx_w-1:0]    mem_rd,
    output logic [hazard_pkg::reg_idx_w-1:0]    mem_rs2,
    output logic [hazard_pkg::csr_addr_w-1:0]   mem_csr,
    output logic [hazard_pkg::trap_w-1:0]       mem_trap,
    output logic                                wb_valid,
    output logic [hazard_pkg::wb_ctrl_w-1:0]    wb_ctrl,
    output logic [hazard_pkg::reg_idx_w-1:0]    wb_rd,
    output logic [hazard_pkg::csr_addr_w-1:0]   wb_csr,
    output logic [hazard_pkg::trap_w-1:0]       wb_trap_raw,
    output logic                                retire_valid,
    output logic [hazard_pkg::reg_idx_w-1:0]    retire_rd,
    output logic [hazard_pkg::wb_ctrl_w-1:0]    retire_wb_ctrl,
    output logic [hazard_pkg::trap_w-1:0]       retire_trap
);

    logic                              id_hold;
    logic                              exe_hold;
    logic                              mem_hold;
    logic [hazard_pkg::reg_idx_w-1:0]  id_rd;
    logic [hazard_pkg::exe_ctrl_w-1:0] id_exe_ctrl;
    logic [hazard_pkg::exe_src_w-1:0]  id_exe_src;
    logic [hazard_pkg::mem_ctrl_w-1:0] id_mem_ctrl;
    logic [hazard_pkg::wb_ctrl_w-1:0]  id_wb_ctrl;
    logic [hazard_pkg::csr_addr_w-1:0] id_csr;
    logic [hazard_pkg::mem_ctrl_w-1:0] exe_mem_ctrl;

    // A conflict freezes its stage and everything behind it
    assign mem_hold   = mem_conflict;
    assign exe_hold   = exe_conflict | mem_hold;
    assign id_hold    = id_conflict | exe_hold;
    assign id_load_ok = !id_valid || !id_hold;

    // The stage just ahead of the frozen ones takes a bubble
    always_ff @(posedge clk) begin
        if (rst) begin
            id_valid  <= 1'b0;
            exe_valid <= 1'b0;
            mem_valid <= 1'b0;
            wb_valid  <= 1'b0;
        end else begin
            if (capture) begin
                id_valid <= 1'b1;
            end else if (!id_hold) begin
                id_valid <= 1'b0;
            end
            if (!exe_hold) begin
                exe_valid <= id_valid & ~id_hold;
            end
            if (!mem_hold) begin
                mem_valid <= exe_valid & ~exe_hold;
            end
            wb_valid <= mem_valid & ~mem_hold;  // WB never stalls
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            id_type     <= issue_op_type;
            id_rs1      <= issue_rs1;
            id_rs2      <= issue_rs2;
            id_rd       <= issue_rd;
            id_exe_ctrl <= issue_exe_ctrl;
            id_exe_src  <= issue_exe_src;
            id_mem_ctrl <= issue_mem_ctrl;
            id_wb_ctrl  <= issue_wb_ctrl;
            id_csr      <= issue_csr;
            id_trap     <= issue_trap;
        end
        if (!exe_hold) begin
            exe_ctrl     <= id_exe_ctrl;
            exe_src      <= id_exe_src;
            exe_mem_ctrl <= id_mem_ctrl;
            exe_wb_ctrl  <= id_wb_ctrl;
            exe_rd       <= id_rd;
            exe_rs1      <= id_rs1;
            exe_rs2      <= id_rs2;
            exe_csr      <= id_csr;
            exe_trap     <= id_trap;
        end
        if (!mem_hold) begin
            mem_ctrl    <= exe_mem_ctrl;
            mem_wb_ctrl <= exe_wb_ctrl;
            mem_rd      <= exe_rd;
            mem_rs2     <= exe_rs2;
            mem_csr     <= exe_csr;
            mem_trap    <= exe_trap;
        end
        wb_ctrl     <= mem_wb_ctrl;
        wb_rd       <= mem_rd;
        wb_csr      <= mem_csr;
        wb_trap_raw <= mem_trap;
    end

    assign retire_valid   = wb_valid;
    assign retire_rd      = wb_valid ? wb_rd : '0;
    assign retire_wb_ctrl = wb_valid ? wb_ctrl : hazard_pkg::wb_nop;
    assign retire_trap    = wb_trap;  // Masked by the detector

endmodule

`default_nettype wire

/* logic/conflict_detector.sv */
// Pipeline conflict detector
`default_nettype none

module conflict_detector (
    input  logic                                id_valid,
    input  logic [hazard_pkg::type_w-1:0]       id_type,
    input  logic [hazard_pkg::reg_idx_w-1:0]    id_rs1,
    input  logic [hazard_pkg::reg_idx_w-1:0]    id_rs2,
    input  logic [hazard_pkg::trap_w-1:0]       id_trap,
    input  logic                                exe_valid,
    input  logic [hazard_pkg::exe_ctrl_w-1:0]   exe_ctrl,
    input  logic [hazard_pkg::exe_src_w-1:0]    exe_src,
    input  logic [hazard_pkg::wb_ctrl_w-1:0]    exe_wb_ctrl,
    input  logic [hazard_pkg::reg_idx_w-1:0]    exe_rd,
    input  logic [hazard_pkg::reg_idx_w-1:0]    exe_rs1,
    input  logic [hazard_pkg::reg_idx_w-1:0]    exe_rs2,
    input  logic [hazard_pkg::csr_addr_w-1:0]   exe_csr,
    input  logic [hazard_pkg::trap_w-1:0]       exe_trap,
    input  logic                                mem_valid,
    input  logic [hazard_pkg::mem_ctrl_w-1:0]   mem_ctrl,
    input  logic [hazard_pkg::wb_ctrl_w-1:0]    mem_wb_ctrl,
    input  logic [hazard_pkg::reg_idx_w-1:0]    mem_rd,
    input  logic [hazard_pkg::reg_idx_w-1:0]    mem_rs2,
    input  logic [hazard_pkg::csr_addr_w-1:0]   mem_csr,
    input  logic [hazard_pkg::trap_w-1:0]       mem_trap,
    input  logic                                wb_valid,
    input  logic [hazard_pkg::wb_ctrl_w-1:0]    wb_ctrl,
    input  logic [hazard_pkg::reg_idx_w-1:0]    wb_rd,
    input  logic [hazard_pkg::csr_addr_w-1:0]   wb_csr,
    input  logic [hazard_pkg::trap_w-1:0]       wb_trap,
    output logic                                id_conflict,
    output logic                                exe_conflict,
    output logic                                mem_conflict,
    output logic [hazard_pkg::trap_w-1:0]       wb_trap_out
);

    logic id_rs1_rd;
    logic id_rs2_rd;
    logic exe_rs1_rd;
    logic exe_rs2_rd;
    logic exe_csr_rd;
    logic mem_rs2_rd;
    logic exe_reg_wr;
    logic mem_reg_wr;
    logic mem_csr_wr;
    logic wb_reg_wr;
    logic wb_csr_wr;

    function automatic logic writes_reg(
        input logic                             valid,
        input logic [hazard_pkg::wb_ctrl_w-1:0] code
    );
        writes_reg = valid && (code inside {hazard_pkg::wb_exe, hazard_pkg::wb_mem,
            hazard_pkg::wb_imm, hazard_pkg::wb_snpc, hazard_pkg::wb_csr_rs1,
            hazard_pkg::wb_csr_exe, hazard_pkg::wb_csr_zimm, hazard_pkg::wb_csr_ro});
    endfunction

    function automatic logic writes_csr(
        input logic                             valid,
        input logic [hazard_pkg::wb_ctrl_w-1:0] code
    );
        writes_csr = valid && (code inside {hazard_pkg::wb_csr_rs1,
            hazard_pkg::wb_csr_exe, hazard_pkg::wb_csr_zimm});
    endfunction

    function automatic logic reg_hit(
        input logic                             wr,
        input logic [hazard_pkg::reg_idx_w-1:0] dst,
        input logic [hazard_pkg::reg_idx_w-1:0] src
    );
        reg_hit = wr && (dst == src);
    endfunction

    assign exe_reg_wr = writes_reg(exe_valid, exe_wb_ctrl);
    assign mem_reg_wr = writes_reg(mem_valid, mem_wb_ctrl);
    assign wb_reg_wr  = writes_reg(wb_valid, wb_ctrl);
    assign mem_csr_wr = writes_csr(mem_valid, mem_wb_ctrl);
    assign wb_csr_wr  = writes_csr(wb_valid, wb_ctrl);

    // Only branches and jalr resolve in ID
    assign id_rs1_rd = id_valid && (id_type == hazard_pkg::type_branches
                                    || id_type == hazard_pkg::type_jalr);
    assign id_rs2_rd = id_valid && (id_type == hazard_pkg::type_branches);

    always_comb begin
        exe_rs1_rd = 1'b0;
        exe_rs2_rd = 1'b0;
        exe_csr_rd = 1'b0;
        if (exe_valid && exe_ctrl != hazard_pkg::exe_nop) begin
            case (exe_src)
                hazard_pkg::src_r_r: begin
                    exe_rs1_rd = 1'b1;
                    exe_rs2_rd = 1'b1;
                end
                hazard_pkg::src_r_i: begin
                    exe_rs1_rd = 1'b1;
                end
                hazard_pkg::src_r_csr, hazard_pkg::src_notr_csr: begin
                    exe_rs1_rd = 1'b1;
                    exe_csr_rd = 1'b1;
                end
                hazard_pkg::src_csr_zimm, hazard_pkg::src_csr_notzimm: begin
                    exe_csr_rd = 1'b1;
                end
                hazard_pkg::src_nop, hazard_pkg::src_pc_i: begin
                    exe_rs1_rd = 1'b0;  // No operand from the register file
                end
                default: begin
                    exe_rs1_rd = 1'b0;
                end
            endcase
        end
    end

    assign mem_rs2_rd = mem_valid && (mem_ctrl inside {hazard_pkg::mem_sb, hazard_pkg::mem_sh,
                                                       hazard_pkg::mem_sw, hazard_pkg::mem_sd});

    assign id_conflict =
        (id_rs1_rd && (reg_hit(exe_reg_wr, exe_rd, id_rs1) || reg_hit(mem_reg_wr, mem_rd, id_rs1)
                       || reg_hit(wb_reg_wr, wb_rd, id_rs1))) ||
        (id_rs2_rd && (reg_hit(exe_reg_wr, exe_rd, id_rs2) || reg_hit(mem_reg_wr, mem_rd, id_rs2)
                       || reg_hit(wb_reg_wr, wb_rd, id_rs2)));

    assign exe_conflict =
        (exe_rs1_rd && (reg_hit(mem_reg_wr, mem_rd, exe_rs1)
                        || reg_hit(wb_reg_wr, wb_rd, exe_rs1))) ||
        (exe_rs2_rd && (reg_hit(mem_reg_wr, mem_rd, exe_rs2)
                        || reg_hit(wb_reg_wr, wb_rd, exe_rs2))) ||
        (exe_csr_rd && ((mem_csr_wr && exe_csr == mem_csr)
                        || (wb_csr_wr && exe_csr == wb_csr)));

    // Store data is the last register read in the pipe
    assign mem_conflict = mem_rs2_rd && reg_hit(wb_reg_wr, wb_rd, mem_rs2);

    assign wb_trap_out = wb_valid ? wb_trap : hazard_pkg::trap_nop;

endmodule

`default_nettype wire

/* logic/issue_handshake_fsm.sv */
// Four-phase issue handshake
`default_nettype none

module issue_handshake_fsm (
    input  logic clk,
    input  logic rst,
    input  logic req,
    input  logic id_load_ok,
    output logic ack,
    output logic capture
);

    logic [hazard_pkg::state_w-1:0] state;

    // Only an idle FSM may take a new op, so a held req is seen once
    assign capture = (state == hazard_pkg::st_idle) && req && id_load_ok;
    assign ack     = (state == hazard_pkg::st_acked);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= hazard_pkg::st_idle;
        end else begin
            case (state)
                hazard_pkg::st_idle: begin
                    if (capture) begin
                        state <= hazard_pkg::st_acked;  // ack rises with the ID load
                    end
                end
                hazard_pkg::st_acked: begin
                    if (!req) begin
                        state <= hazard_pkg::st_wait_low;  // Drop ack
                    end
                end
                hazard_pkg::st_wait_low: begin
                    // req is seen low once more with ack low
                    if (!req) begin
                        state <= hazard_pkg::st_idle;
                    end
                end
                default: begin
                    state <= hazard_pkg::st_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/hazard_pkg.sv */
// Hazard unit shared constants
`default_nettype none

package hazard_pkg;

    localparam int reg_idx_w  = 5;
    localparam int csr_addr_w = 12;
    localparam int count_w    = 16;
    localparam int type_w     = 3;
    localparam int exe_ctrl_w = 5;
    localparam int exe_src_w  = 3;
    localparam int mem_ctrl_w = 4;
    localparam int wb_ctrl_w  = 4;
    localparam int trap_w     = 4;
    localparam int state_w    = 2;

    // Micro-op types seen by ID
    localparam logic [type_w-1:0] type_other    = 3'd0;
    localparam logic [type_w-1:0] type_branches = 3'd1;
    localparam logic [type_w-1:0] type_jalr     = 3'd2;

    localparam logic [wb_ctrl_w-1:0] wb_nop      = 4'd0;
    localparam logic [wb_ctrl_w-1:0] wb_exe      = 4'd1;
    localparam logic [wb_ctrl_w-1:0] wb_mem      = 4'd2;
    localparam logic [wb_ctrl_w-1:0] wb_imm      = 4'd3;
    localparam logic [wb_ctrl_w-1:0] wb_snpc     = 4'd4;
    localparam logic [wb_ctrl_w-1:0] wb_csr_rs1  = 4'd5;  // Register and CSR
    localparam logic [wb_ctrl_w-1:0] wb_csr_exe  = 4'd6;
    localparam logic [wb_ctrl_w-1:0] wb_csr_zimm = 4'd7;
    localparam logic [wb_ctrl_w-1:0] wb_csr_ro   = 4'd8;  // Register only

    localparam logic [exe_ctrl_w-1:0] exe_nop = 5'd0;

    localparam logic [exe_src_w-1:0] src_nop         = 3'd0;
    localparam logic [exe_src_w-1:0] src_r_r         = 3'd1;
    localparam logic [exe_src_w-1:0] src_r_i         = 3'd2;
    localparam logic [exe_src_w-1:0] src_pc_i        = 3'd3;
    localparam logic [exe_src_w-1:0] src_r_csr       = 3'd4;
    localparam logic [exe_src_w-1:0] src_notr_csr    = 3'd5;
    localparam logic [exe_src_w-1:0] src_csr_zimm    = 3'd6;
    localparam logic [exe_src_w-1:0] src_csr_notzimm = 3'd7;

    localparam logic [mem_ctrl_w-1:0] mem_nop = 4'd0;
    localparam logic [mem_ctrl_w-1:0] mem_lb  = 4'd1;
    localparam logic [mem_ctrl_w-1:0] mem_lh  = 4'd2;
    localparam logic [mem_ctrl_w-1:0] mem_lw  = 4'd3;
    localparam logic [mem_ctrl_w-1:0] mem_ld  = 4'd4;
    localparam logic [mem_ctrl_w-1:0] mem_lbu = 4'd5;
    localparam logic [mem_ctrl_w-1:0] mem_lhu = 4'd6;
    localparam logic [mem_ctrl_w-1:0] mem_lwu = 4'd7;
    localparam logic [mem_ctrl_w-1:0] mem_sb  = 4'd8;
    localparam logic [mem_ctrl_w-1:0] mem_sh  = 4'd9;
    localparam logic [mem_ctrl_w-1:0] mem_sw  = 4'd10;
    localparam logic [mem_ctrl_w-1:0] mem_sd  = 4'd11;

    localparam logic [trap_w-1:0] trap_nop = 4'd0;

    // Issue FSM encoding
    localparam logic [state_w-1:0] st_idle     = 2'd0;
    localparam logic [state_w-1:0] st_acked    = 2'd1;
    localparam logic [state_w-1:0] st_wait_low = 2'd2;

endpackage

`default_nettype wire
